//--- source/axis_pkg.sv
package axis_pkg;

    // ========================================================================
    // Stream field widths
    // ========================================================================

    // Bytes per beat on tdata
    localparam int AXIS_DATA_BYTES = 8;

    // Sideband widths
    localparam int AXIS_ID_W   = 4;
    localparam int AXIS_DEST_W = 4;
    localparam int AXIS_USER_W = 8;

    // ========================================================================
    // Stream field types
    // ========================================================================

    // Byte-addressable data word
    typedef logic [AXIS_DATA_BYTES-1:0][7:0] axis_data_t;

    // One keep bit per data byte
    typedef logic [AXIS_DATA_BYTES-1:0] axis_keep_t;

    typedef logic [AXIS_ID_W-1:0]   axis_id_t;
    typedef logic [AXIS_DEST_W-1:0] axis_dest_t;
    typedef logic [AXIS_USER_W-1:0] axis_user_t;

endpackage

//--- source/axis_if.sv
`timescale 1ns/10ps

interface axis_if;
    import axis_pkg::*;

    // Handshake
    logic       tvalid;
    logic       tready;

    // Beat payload
    axis_data_t tdata;
    axis_keep_t tkeep;
    logic       tlast;
    axis_id_t   tid;
    axis_dest_t tdest;
    axis_user_t tuser;

    // Sender side, owns valid and payload
    modport tx (
        output tvalid,
        input  tready,
        output tdata,
        output tkeep,
        output tlast,
        output tid,
        output tdest,
        output tuser
    );

    // Receiver side, owns ready
    modport rx (
        input  tvalid,
        output tready,
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tid,
        input  tdest,
        input  tuser
    );

endinterface

//--- source/axis_pipe_stage.sv
`timescale 1ns/10ps

module axis_pipe_stage (
    input logic aclk,
    input logic aresetn,
    axis_if.rx  up,
    axis_if.tx  down
);
    import axis_pkg::*;

    logic       valid_q;
    axis_data_t data_q;
    axis_keep_t keep_q;
    logic       last_q;
    axis_id_t   id_q;
    axis_dest_t dest_q;
    axis_user_t user_q;

    logic       accept;
    logic       load;

    // Slot is free when empty or when the held beat leaves this cycle
    assign accept = !valid_q || down.tready;
    assign load   = up.tvalid && accept;

    assign up.tready = accept;

    // Valid flag
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= up.tvalid;
        end
    end

    // Payload register, only written on a transfer in
    always_ff @(posedge aclk) begin
        if (load) begin
            data_q <= up.tdata;
            keep_q <= up.tkeep;
            last_q <= up.tlast;
            id_q   <= up.tid;
            dest_q <= up.tdest;
            user_q <= up.tuser;
        end
    end

    // Registered beat out
    assign down.tvalid = valid_q;
    assign down.tdata  = data_q;
    assign down.tkeep  = keep_q;
    assign down.tlast  = last_q;
    assign down.tid    = id_q;
    assign down.tdest  = dest_q;
    assign down.tuser  = user_q;

endmodule

//--- source/axis_stage_chain.sv
`timescale 1ns/10ps

module axis_stage_chain #(
    parameter int PIPE_STAGES = 2
) (
    input logic aclk,
    input logic aresetn,
    axis_if.rx  up,
    axis_if.tx  down
);

    generate
        if (PIPE_STAGES > 0) begin : g_stages
            // link[0] is the chain entry, link[PIPE_STAGES] the exit
            axis_if link [PIPE_STAGES+1] ();

            assign link[0].tvalid = up.tvalid;
            assign link[0].tdata  = up.tdata;
            assign link[0].tkeep  = up.tkeep;
            assign link[0].tlast  = up.tlast;
            assign link[0].tid    = up.tid;
            assign link[0].tdest  = up.tdest;
            assign link[0].tuser  = up.tuser;
            assign up.tready      = link[0].tready;

            for (genvar i = 0; i < PIPE_STAGES; i++) begin : g_slice
                axis_pipe_stage i_stage (
                    .aclk    (aclk),
                    .aresetn (aresetn),
                    .up      (link[i]),
                    .down    (link[i+1])
                );
            end

            assign down.tvalid = link[PIPE_STAGES].tvalid;
            assign down.tdata  = link[PIPE_STAGES].tdata;
            assign down.tkeep  = link[PIPE_STAGES].tkeep;
            assign down.tlast  = link[PIPE_STAGES].tlast;
            assign down.tid    = link[PIPE_STAGES].tid;
            assign down.tdest  = link[PIPE_STAGES].tdest;
            assign down.tuser  = link[PIPE_STAGES].tuser;
            assign link[PIPE_STAGES].tready = down.tready;
        end else begin : g_direct
            // No slices, the bypass path is combinational
            assign down.tvalid = up.tvalid;
            assign down.tdata  = up.tdata;
            assign down.tkeep  = up.tkeep;
            assign down.tlast  = up.tlast;
            assign down.tid    = up.tid;
            assign down.tdest  = up.tdest;
            assign down.tuser  = up.tuser;
            assign up.tready   = down.tready;
        end
    endgenerate

endmodule

//--- source/axis_path_switch.sv
`timescale 1ns/10ps

module axis_path_switch (
    input logic bypass,
    axis_if.rx  src,
    axis_if.tx  blk_out,
    axis_if.rx  blk_ret,
    axis_if.tx  chain_in,
    axis_if.rx  chain_out,
    axis_if.tx  res
);

    // ========================================================================
    // Input steering
    // ========================================================================

    // Only the selected path ever sees a valid beat
    assign blk_out.tvalid  = bypass ? 1'b0 : src.tvalid;
    assign chain_in.tvalid = bypass ? src.tvalid : 1'b0;

    // Payload fans out to both paths
    assign blk_out.tdata  = src.tdata;
    assign blk_out.tkeep  = src.tkeep;
    assign blk_out.tlast  = src.tlast;
    assign blk_out.tid    = src.tid;
    assign blk_out.tdest  = src.tdest;
    assign blk_out.tuser  = src.tuser;

    assign chain_in.tdata = src.tdata;
    assign chain_in.tkeep = src.tkeep;
    assign chain_in.tlast = src.tlast;
    assign chain_in.tid   = src.tid;
    assign chain_in.tdest = src.tdest;
    assign chain_in.tuser = src.tuser;

    // Source ready from whichever path is selected
    assign src.tready = bypass ? chain_in.tready : blk_out.tready;

    // ========================================================================
    // Output mux and tready demux
    // ========================================================================

    assign res.tvalid = bypass ? chain_out.tvalid : blk_ret.tvalid;
    assign res.tdata  = bypass ? chain_out.tdata  : blk_ret.tdata;
    assign res.tkeep  = bypass ? chain_out.tkeep  : blk_ret.tkeep;
    assign res.tlast  = bypass ? chain_out.tlast  : blk_ret.tlast;
    assign res.tid    = bypass ? chain_out.tid    : blk_ret.tid;
    assign res.tdest  = bypass ? chain_out.tdest  : blk_ret.tdest;
    assign res.tuser  = bypass ? chain_out.tuser  : blk_ret.tuser;

    // Unselected return path is held off
    assign blk_ret.tready   = bypass ? 1'b0 : res.tready;
    assign chain_out.tready = bypass ? res.tready : 1'b0;

endmodule

//--- source/axis_bypass_top.sv
`timescale 1ns/10ps

module axis_bypass_top #(
    parameter int PIPE_STAGES = 2
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 bypass,

    // Input stream
    input  logic                 in_tvalid,
    output logic                 in_tready,
    input  axis_pkg::axis_data_t in_tdata,
    input  axis_pkg::axis_keep_t in_tkeep,
    input  logic                 in_tlast,
    input  axis_pkg::axis_id_t   in_tid,
    input  axis_pkg::axis_dest_t in_tdest,
    input  axis_pkg::axis_user_t in_tuser,

    // Stream to the processing block
    output logic                 to_blk_tvalid,
    input  logic                 to_blk_tready,
    output axis_pkg::axis_data_t to_blk_tdata,
    output axis_pkg::axis_keep_t to_blk_tkeep,
    output logic                 to_blk_tlast,
    output axis_pkg::axis_id_t   to_blk_tid,
    output axis_pkg::axis_dest_t to_blk_tdest,
    output axis_pkg::axis_user_t to_blk_tuser,

    // Stream back from the processing block
    input  logic                 from_blk_tvalid,
    output logic                 from_blk_tready,
    input  axis_pkg::axis_data_t from_blk_tdata,
    input  axis_pkg::axis_keep_t from_blk_tkeep,
    input  logic                 from_blk_tlast,
    input  axis_pkg::axis_id_t   from_blk_tid,
    input  axis_pkg::axis_dest_t from_blk_tdest,
    input  axis_pkg::axis_user_t from_blk_tuser,

    // Output stream
    output logic                 out_tvalid,
    input  logic                 out_tready,
    output axis_pkg::axis_data_t out_tdata,
    output axis_pkg::axis_keep_t out_tkeep,
    output logic                 out_tlast,
    output axis_pkg::axis_id_t   out_tid,
    output axis_pkg::axis_dest_t out_tdest,
    output axis_pkg::axis_user_t out_tuser
);

    axis_if top_in_if ();
    axis_if chain_in_if ();
    axis_if chain_out_if ();
    axis_if blk_out_if ();
    axis_if blk_ret_if ();
    axis_if res_if ();

    // ========================================================================
    // Port flattening
    // ========================================================================

    assign top_in_if.tvalid = in_tvalid;
    assign top_in_if.tdata  = in_tdata;
    assign top_in_if.tkeep  = in_tkeep;
    assign top_in_if.tlast  = in_tlast;
    assign top_in_if.tid    = in_tid;
    assign top_in_if.tdest  = in_tdest;
    assign top_in_if.tuser  = in_tuser;
    assign in_tready        = top_in_if.tready;

    assign to_blk_tvalid     = blk_out_if.tvalid;
    assign to_blk_tdata      = blk_out_if.tdata;
    assign to_blk_tkeep      = blk_out_if.tkeep;
    assign to_blk_tlast      = blk_out_if.tlast;
    assign to_blk_tid        = blk_out_if.tid;
    assign to_blk_tdest      = blk_out_if.tdest;
    assign to_blk_tuser      = blk_out_if.tuser;
    assign blk_out_if.tready = to_blk_tready;

    assign blk_ret_if.tvalid = from_blk_tvalid;
    assign blk_ret_if.tdata  = from_blk_tdata;
    assign blk_ret_if.tkeep  = from_blk_tkeep;
    assign blk_ret_if.tlast  = from_blk_tlast;
    assign blk_ret_if.tid    = from_blk_tid;
    assign blk_ret_if.tdest  = from_blk_tdest;
    assign blk_ret_if.tuser  = from_blk_tuser;
    assign from_blk_tready   = blk_ret_if.tready;

    assign out_tvalid    = res_if.tvalid;
    assign out_tdata     = res_if.tdata;
    assign out_tkeep     = res_if.tkeep;
    assign out_tlast     = res_if.tlast;
    assign out_tid       = res_if.tid;
    assign out_tdest     = res_if.tdest;
    assign out_tuser     = res_if.tuser;
    assign res_if.tready = out_tready;

    // ========================================================================
    // Switch and bypass chain
    // ========================================================================

    axis_path_switch i_switch (
        .bypass    (bypass),
        .src       (top_in_if),
        .blk_out   (blk_out_if),
        .blk_ret   (blk_ret_if),
        .chain_in  (chain_in_if),
        .chain_out (chain_out_if),
        .res       (res_if)
    );

    axis_stage_chain #(
        .PIPE_STAGES (PIPE_STAGES)
    ) i_chain (
        .aclk    (aclk),
        .aresetn (aresetn),
        .up      (chain_in_if),
        .down    (chain_out_if)
    );

endmodule

//--- tests/axis_bypass_props.sv
`timescale 1ns/10ps

module axis_bypass_props (
    input logic                 aclk,
    input logic                 aresetn,
    input logic                 bypass,
    input logic                 out_tvalid,
    input logic                 out_tready,
    input axis_pkg::axis_data_t out_tdata,
    input axis_pkg::axis_keep_t out_tkeep,
    input logic                 out_tlast,
    input axis_pkg::axis_id_t   out_tid,
    input axis_pkg::axis_dest_t out_tdest,
    input axis_pkg::axis_user_t out_tuser,
    input logic                 to_blk_tvalid,
    input logic                 from_blk_tready
);

    // Stalled output beat must hold until taken
    out_payload_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (out_tvalid && !out_tready) |=> (out_tvalid &&
        $stable({out_tdata, out_tkeep, out_tlast, out_tid, out_tdest, out_tuser})))
        else $error("out stream dropped or changed a stalled beat");

    // Block is isolated in bypass mode
    blk_valid_off: assert property (@(posedge aclk) bypass |-> !to_blk_tvalid)
        else $error("to_blk_tvalid high while bypass is high");

    blk_ready_off: assert property (@(posedge aclk) bypass |-> !from_blk_tready)
        else $error("from_blk_tready high while bypass is high");

    out_idle_in_reset: assert property (@(posedge aclk) !aresetn |-> !out_tvalid)
        else $error("out_tvalid high while aresetn is low");

endmodule

bind axis_bypass_top axis_bypass_props i_props (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .bypass          (bypass),
    .out_tvalid      (out_tvalid),
    .out_tready      (out_tready),
    .out_tdata       (out_tdata),
    .out_tkeep       (out_tkeep),
    .out_tlast       (out_tlast),
    .out_tid         (out_tid),
    .out_tdest       (out_tdest),
    .out_tuser       (out_tuser),
    .to_blk_tvalid   (to_blk_tvalid),
    .from_blk_tready (from_blk_tready)
);

//--- tests/tb_axis_bypass.sv
`timescale 1ns/10ps

module tb_axis_bypass;
    import axis_pkg::*;

    localparam int PIPE_STAGES  = 2;
    localparam int BEAT_TIMEOUT = 64;

    // One stream beat in port concatenation order
    typedef struct packed {
        axis_data_t data;
        axis_keep_t keep;
        logic       last;
        axis_id_t   id;
        axis_dest_t dest;
        axis_user_t user;
    } beat_t;

    logic       aclk;
    logic       aresetn;
    logic       bypass;
    logic       in_tvalid,       in_tready,       in_tlast;
    logic       to_blk_tvalid,   to_blk_tready,   to_blk_tlast;
    logic       from_blk_tvalid, from_blk_tready, from_blk_tlast;
    logic       out_tvalid,      out_tready,      out_tlast;
    axis_data_t in_tdata,  to_blk_tdata, from_blk_tdata, out_tdata;
    axis_keep_t in_tkeep,  to_blk_tkeep, from_blk_tkeep, out_tkeep;
    axis_id_t   in_tid,    to_blk_tid,   from_blk_tid,   out_tid;
    axis_dest_t in_tdest,  to_blk_tdest, from_blk_tdest, out_tdest;
    axis_user_t in_tuser,  to_blk_tuser, from_blk_tuser, out_tuser;

    logic [31:0] rng_state   = 32'd64069;
    int          check_count = 0;
    int          error_count = 0;

    axis_bypass_top #(
        .PIPE_STAGES (PIPE_STAGES)
    ) i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = xorshift32();
        return r[16];
    endfunction

    function automatic beat_t random_beat();
        beat_t       b;
        logic [31:0] r;
        b.data = {xorshift32(), xorshift32()};
        r      = xorshift32();
        b.keep = r[7:0];
        b.last = r[8];
        b.id   = r[12:9];
        b.dest = r[16:13];
        b.user = r[24:17];
        return b;
    endfunction

    function automatic beat_t in_beat();
        return {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest, in_tuser};
    endfunction

    function automatic beat_t to_blk_beat();
        return {to_blk_tdata, to_blk_tkeep, to_blk_tlast, to_blk_tid, to_blk_tdest, to_blk_tuser};
    endfunction

    function automatic beat_t out_beat();
        return {out_tdata, out_tkeep, out_tlast, out_tid, out_tdest, out_tuser};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_beat(input string prefix, input beat_t got, input beat_t exp);
        check_value({prefix, "_tdata"}, got.data, exp.data);
        check_value({prefix, "_tkeep"}, got.keep, exp.keep);
        check_value({prefix, "_tlast"}, got.last, exp.last);
        check_value({prefix, "_tid"},   got.id,   exp.id);
        check_value({prefix, "_tdest"}, got.dest, exp.dest);
        check_value({prefix, "_tuser"}, got.user, exp.user);
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout: no progress while waiting for %s", what);
    endtask

    task automatic drive_in(input logic valid, input beat_t b);
        in_tvalid <= valid;
        {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest, in_tuser} <= b;
    endtask

    task automatic drive_from_blk(input logic valid, input beat_t b);
        from_blk_tvalid <= valid;
        {from_blk_tdata, from_blk_tkeep, from_blk_tlast,
         from_blk_tid, from_blk_tdest, from_blk_tuser} <= b;
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset();
        // Bypass is high here, so out_tvalid shows the last stage valid
        @(negedge aclk);
        check_value("out_tvalid", out_tvalid, 1'b0);
        @(posedge aclk);
        bypass <= 1'b0;
        @(negedge aclk);
        check_value("to_blk_tvalid", to_blk_tvalid, 1'b0);
    endtask

    // Input straight through to the block with ready toggling
    task automatic test_block_forward(input int n);
        beat_t exp;
        int    done    = 0;
        int    idle    = 0;
        logic  pending = 1'b0;
        @(posedge aclk);
        bypass     <= 1'b0;
        out_tready <= 1'b1;
        drive_from_blk(1'b0, '0);
        while (done < n) begin
            @(posedge aclk);
            if (!pending) begin
                exp = random_beat();
                drive_in(1'b1, exp);
                pending = 1'b1;
            end
            to_blk_tready <= random_bit();
            @(negedge aclk);
            check_value("to_blk_tvalid", to_blk_tvalid, 1'b1);
            check_beat("to_blk", to_blk_beat(), exp);
            check_value("in_tready", in_tready, to_blk_tready);
            check_value("out_tvalid", out_tvalid, 1'b0);
            if (in_tvalid && in_tready) begin
                done++;
                pending = 1'b0;
                idle    = 0;
            end else if (++idle > BEAT_TIMEOUT) begin
                report_timeout("an in_tready in block mode");
                break;
            end
        end
        @(posedge aclk);
        drive_in(1'b0, '0);
        to_blk_tready <= 1'b0;
    endtask

    // Block return straight through to the output
    task automatic test_block_return(input int n);
        beat_t exp;
        int    done    = 0;
        int    idle    = 0;
        logic  pending = 1'b0;
        while (done < n) begin
            @(posedge aclk);
            if (!pending) begin
                exp = random_beat();
                drive_from_blk(1'b1, exp);
                pending = 1'b1;
            end
            out_tready <= random_bit();
            @(negedge aclk);
            check_value("out_tvalid", out_tvalid, 1'b1);
            check_beat("out", out_beat(), exp);
            check_value("from_blk_tready", from_blk_tready, out_tready);
            check_value("to_blk_tvalid", to_blk_tvalid, 1'b0);
            if (from_blk_tvalid && from_blk_tready) begin
                done++;
                pending = 1'b0;
                idle    = 0;
            end else if (++idle > BEAT_TIMEOUT) begin
                report_timeout("a from_blk_tready in block mode");
                break;
            end
        end
        @(posedge aclk);
        drive_from_blk(1'b0, '0);
        out_tready <= 1'b1;
    endtask

    // Stream through the stage chain with optional gaps and stalls
    task automatic test_bypass_stream(input int n, input logic random_flow,
                                      input logic check_latency);
        beat_t sent_q[$];
        int    acc_q[$];
        beat_t exp;
        int    acc;
        int    sent     = 0;
        int    received = 0;
        int    cycle    = 0;
        int    idle     = 0;
        logic  took_in  = 1'b0;
        @(posedge aclk);
        bypass <= 1'b1;
        while (received < n) begin
            @(posedge aclk);
            if (!in_tvalid || took_in) begin
                if (sent < n && (!random_flow || random_bit())) begin
                    drive_in(1'b1, random_beat());
                    sent++;
                end else begin
                    drive_in(1'b0, '0);
                end
            end
            out_tready <= random_flow ? random_bit() : 1'b1;
            @(negedge aclk);
            cycle++;
            took_in = in_tvalid && in_tready;
            if (took_in) begin
                sent_q.push_back(in_beat());
                acc_q.push_back(cycle);
            end
            check_value("to_blk_tvalid", to_blk_tvalid, 1'b0);
            check_value("from_blk_tready", from_blk_tready, 1'b0);
            if (!random_flow && in_tvalid)
                check_value("in_tready", in_tready, 1'b1);
            if (out_tvalid && out_tready) begin
                if (sent_q.size() == 0) begin
                    error_count++;
                    $display("Output beat arrived with no input beat left to match it");
                end else begin
                    exp = sent_q.pop_front();
                    acc = acc_q.pop_front();
                    check_beat("out", out_beat(), exp);
                    if (check_latency)
                        check_value("out_tvalid latency", cycle - acc, PIPE_STAGES);
                end
                received++;
                idle = 0;
            end else if (++idle > BEAT_TIMEOUT) begin
                report_timeout("a beat on the bypass output");
                break;
            end
        end
        @(posedge aclk);
        drive_in(1'b0, '0);
        out_tready <= 1'b1;
        // Chain must be empty with nothing left over
        repeat (3) begin
            @(negedge aclk);
            check_value("out_tvalid", out_tvalid, 1'b0);
        end
        check_value("unmatched input beats", sent_q.size(), 0);
        @(posedge aclk);
        bypass <= 1'b0;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        aresetn         = 1'b0;
        // Chain output drives out_* during and right after reset
        bypass          = 1'b1;
        in_tvalid       = 1'b0;
        {in_tdata, in_tkeep, in_tlast, in_tid, in_tdest, in_tuser} = '0;
        to_blk_tready   = 1'b0;
        from_blk_tvalid = 1'b0;
        {from_blk_tdata, from_blk_tkeep, from_blk_tlast,
         from_blk_tid, from_blk_tdest, from_blk_tuser} = '0;
        out_tready      = 1'b0;

        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        test_reset();
        test_block_forward(8);
        test_block_return(8);
        test_bypass_stream(16, 1'b0, 1'b1);
        test_bypass_stream(32, 1'b1, 1'b0);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
source/axis_pkg.sv
source/axis_if.sv
source/axis_pipe_stage.sv
source/axis_stage_chain.sv
source/axis_path_switch.sv
source/axis_bypass_top.sv
tests/axis_bypass_props.sv
tests/tb_axis_bypass.sv

//--- Bender.yml
package:
  name: axis_bypass

sources:
  # RTL in compile order
  - source/axis_pkg.sv
  - source/axis_if.sv
  - source/axis_pipe_stage.sv
  - source/axis_stage_chain.sv
  - source/axis_path_switch.sv
  - source/axis_bypass_top.sv

  # Testbench and bound properties
  - target: test
    files:
      - tests/axis_bypass_props.sv
      - tests/tb_axis_bypass.sv
